//--- all.f
design/tackPkg.sv
design/cycleDecode.sv
design/romAckDelay.sv
design/ciaAckSync.sv
design/busTimeout.sv
design/tackArbiter.sv
design/transferAck.sv
+incdir+verif
verif/transferAckTb.sv

//--- run.sh
#!/bin/sh
# Build and run the transferAck testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f all.f --top-module transferAckTb -o simTransferAck

./obj_dir/simTransferAck | tee sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

if ! grep -q "Result: PASSED" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

//--- verif/transferAckTests.svh
// Transfer ack directed tests

// Outputs idle during and after reset
task automatic resetOutputs;
    int n;
    for (n = 0; n < 15; n++) begin
        @(posedge CLK80);
        #1;
        checkBit("tackOe", tackOe, 1'b0);
        checkBit("tackN", tackN, 1'b1);
        checkSource("termSource", termSource, SrcNone);
    end
    @(posedge CLK80);
    DELAYED_TACK_RST <= 1'b0;
    for (n = 0; n < 8; n++) begin
        @(posedge CLK80);
        #1;
        checkBit("tackOe", tackOe, 1'b0);
        checkBit("tackN", tackN, 1'b1);
        checkSource("termSource", termSource, SrcNone);
    end
endtask

// Exact ROM latency and pulse shape
task automatic romTermination;
    int latency;
    startCycle(32'h00F8_1234, 1'b0);
    waitTackLow(50, latency);
    if (latency >= 0) begin
        checkCount("romLatency", latency, DefRomDelay + 2, DefRomDelay + 2);
        checkPulse(SrcRom);
    end
    checkQuiet(4);
endtask

// TACK follows the first E clock falling edge
task automatic ciaTermination;
    int   waitN;
    int   latency;
    logic prevClk;
    logic fell;
    // Start just after a rising edge of ciaClk
    waitN = 0;
    do begin
        prevClk = ciaClk;
        @(posedge CLK80);
        #1;
        waitN++;
    end while (!(!prevClk && ciaClk) && (waitN < 100));
    if (waitN >= 100) begin
        reportProblem("ciaClk never rose");
    end
    startCycle(32'h00BF_E001, 1'b1);
    fell    = 1'b0;
    latency = 0;
    waitN   = 0;
    prevClk = ciaClk;
    while (waitN < 200) begin
        @(posedge CLK80);
        #1;
        waitN++;
        if (fell) begin
            latency++;
        end
        if (!tackN) begin
            break;
        end
        if (prevClk && !ciaClk) begin
            fell = 1'b1;
        end
        prevClk = ciaClk;
    end
    if (waitN >= 200) begin
        reportProblem("no TACK for the CIA cycle");
    end else if (!fell) begin
        reportProblem("CIA TACK came before the ciaClk falling edge");
    end else begin
        checkCount("ciaLatency", latency, 1, 8);
        checkPulse(SrcCia);
    end
    @(posedge CLK80);
    ciaSelN <= 1'b1;
    checkQuiet(4);
endtask

// Nobody answers so the timeout ends the cycle
task automatic unmappedTimeout;
    int latency;
    startCycle(32'h4000_0000, 1'b0);
    waitTackLow(300, latency);
    if (latency >= 0) begin
        checkCount("timeoutLatency", latency, DefBusTimeout, DefBusTimeout + 3);
        checkPulse(SrcTimeout);
    end
    checkQuiet(4);
endtask

// Agnus and external TACK keep the local sources quiet
task automatic otherAgentTermination;
    startCycle(32'h00DF_F180, 1'b0);
    checkQuiet(300);
    @(posedge CLK80);
    extTackN <= 1'b0;
    @(posedge CLK80);
    extTackN <= 1'b1;
    checkQuiet(4);
    // Unmapped cycle ended by someone else
    startCycle(32'h6000_0010, 1'b0);
    repeat (20) @(posedge CLK80);
    extTackN <= 1'b0;
    @(posedge CLK80);
    extTackN <= 1'b1;
    checkQuiet(300);
endtask

// Seeded mix of ROM and unmapped cycles
task automatic randomCycleMix;
    int          n;
    int          latency;
    logic [31:0] randVal;
    for (n = 0; n < 20; n++) begin
        randVal = $random(seed);
        if (randVal[0]) begin
            startCycle(32'h00F8_0000 | (randVal & 32'h0007_FFFC), 1'b0);
            waitTackLow(50, latency);
            if (latency >= 0) begin
                checkCount("romLatency", latency, DefRomDelay + 2, DefRomDelay + 2);
                checkPulse(SrcRom);
            end
        end else begin
            startCycle(32'h4000_0000 | (randVal & 32'h0FFF_FFFC), 1'b0);
            waitTackLow(300, latency);
            if (latency >= 0) begin
                checkCount("timeoutLatency", latency, DefBusTimeout, DefBusTimeout + 3);
                checkPulse(SrcTimeout);
            end
        end
        checkQuiet(2);
    end
endtask

//--- verif/transferAckTb.sv
// Transfer ack testbench

module transferAckTb;
    import tackPkg::*;

    logic                 CLK80;
    logic                 DELAYED_TACK_RST;
    logic                 tsN;
    logic                 clk40;
    logic [31:0]          cpuAddr;
    logic                 ciaClk;
    logic                 ciaSelN;
    logic                 extTackN;
    logic                 tackN;
    logic                 tackOe;
    termSource_t          termSource;

    integer valueErrors;
    integer otherErrors;
    integer seed;

    transferAck transferAck_i (
        .CLK80            (CLK80),
        .DELAYED_TACK_RST (DELAYED_TACK_RST),
        .tsN              (tsN),
        .clk40            (clk40),
        .cpuAddr          (cpuAddr),
        .ciaClk           (ciaClk),
        .ciaSelN          (ciaSelN),
        .extTackN         (extTackN),
        .tackN            (tackN),
        .tackOe           (tackOe),
        .termSource       (termSource)
    );

    ////////////////////////////////////////
    // Clocks
    ////////////////////////////////////////

    always #4 CLK80 = ~CLK80;

    // 40 MHz phase from a toggle on every CLK80 edge
    always @(posedge CLK80) begin
        clk40 <= ~clk40;
    end

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED t=%0t %s got %0b expected %0b", $time, name, got, exp);
            valueErrors++;
        end
    endtask

    task automatic checkSource(input string name, input termSource_t got,
                               input termSource_t exp);
        if (got !== exp) begin
            $display("FAILED t=%0t %s got %s expected %s", $time, name, got.name(),
                     exp.name());
            valueErrors++;
        end
    endtask

    // Latency inside an inclusive window
    task automatic checkCount(input string name, input int got, input int lo, input int hi);
        if ((got < lo) || (got > hi)) begin
            $display("FAILED t=%0t %s got %0d expected %0d..%0d", $time, name, got, lo, hi);
            valueErrors++;
        end
    endtask

    task automatic reportProblem(input string what);
        $display("Error at t=%0t: %s", $time, what);
        otherErrors++;
    endtask

    ////////////////////////////////////////
    // Stimulus and wait helpers
    ////////////////////////////////////////

    // E clock with 20 cycles high and 20 low
    task automatic runCiaClock;
        forever begin
            repeat (20) @(posedge CLK80);
            ciaClk <= ~ciaClk;
        end
    endtask

    // Returns at edge E where TS is sampled
    task automatic startCycle(input logic [31:0] addr, input logic selCia);
        @(posedge CLK80);
        // Drive TS while clk40 is low so it is seen in the high phase
        if (clk40) begin
            @(posedge CLK80);
        end
        tsN     <= 1'b0;
        cpuAddr <= addr;
        ciaSelN <= !selCia;
        @(posedge CLK80);
        tsN     <= 1'b1;
    endtask

    // Edges counted from E until tackN is seen low or -1 on timeout
    task automatic waitTackLow(input int limit, output int latency);
        int edges;
        edges   = 0;
        latency = -1;
        while (edges < limit) begin
            @(posedge CLK80);
            #1;
            edges++;
            if (!tackN) begin
                latency = edges;
                break;
            end
        end
        if (latency < 0) begin
            reportProblem("no TACK arrived before the wait limit");
        end
    endtask

    // Called with tackN just seen low
    task automatic checkPulse(input termSource_t expSrc);
        checkBit("tackOe", tackOe, 1'b1);
        checkSource("termSource", termSource, expSrc);
        @(posedge CLK80);
        #1;
        checkBit("tackN", tackN, 1'b0);
        checkBit("tackOe", tackOe, 1'b1);
        @(posedge CLK80);
        #1;
        // Actively negated for one cycle
        checkBit("tackN", tackN, 1'b1);
        checkBit("tackOe", tackOe, 1'b1);
        @(posedge CLK80);
        #1;
        checkBit("tackN", tackN, 1'b1);
        checkBit("tackOe", tackOe, 1'b0);
    endtask

    // No TACK of our own for a number of cycles
    task automatic checkQuiet(input int cycles);
        int n;
        for (n = 0; n < cycles; n++) begin
            @(posedge CLK80);
            #1;
            checkBit("tackOe", tackOe, 1'b0);
            checkBit("tackN", tackN, 1'b1);
        end
    endtask

    `include "transferAckTests.svh"

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        CLK80            = 1'b0;
        DELAYED_TACK_RST = 1'b1;
        tsN              = 1'b1;
        clk40            = 1'b0;
        cpuAddr          = 32'h0;
        ciaClk           = 1'b0;
        ciaSelN          = 1'b1;
        extTackN         = 1'b1;
        valueErrors      = 0;
        otherErrors      = 0;
        seed             = 32'h5d425dfa;
        fork
            runCiaClock();
        join_none
        resetOutputs();
        romTermination();
        ciaTermination();
        unmappedTimeout();
        otherAgentTermination();
        randomCycleMix();
        repeat (4) @(posedge CLK80);
        $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
        if ((valueErrors == 0) && (otherErrors == 0)) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- design/transferAck.sv
// Transfer ack top level

module transferAck #(
    parameter logic [2:0] RomDelay   = 3'(tackPkg::DefRomDelay),
    parameter logic [7:0] BusTimeout = 8'(tackPkg::DefBusTimeout)
) (
    input  logic                 CLK80,
    input  logic                 DELAYED_TACK_RST,
    input  logic                 tsN,
    input  logic                 clk40,
    input  logic [31:0]          cpuAddr,
    input  logic                 ciaClk,
    input  logic                 ciaSelN,
    input  logic                 extTackN,
    output logic                 tackN,
    output logic                 tackOe,
    output tackPkg::termSource_t termSource
);
    import tackPkg::*;

    cpuCycle_t cycle;
    ackReq_t   req;
    logic      romReq;
    logic      ciaReq;
    logic      timeoutReq;
    logic      tackSeen;

    ////////////////////////////////////////
    // Cycle decode
    ////////////////////////////////////////

    cycleDecode cycleDecode_i (
        .CLK80            (CLK80),
        .DELAYED_TACK_RST (DELAYED_TACK_RST),
        .tsN              (tsN),
        .clk40            (clk40),
        .cpuAddr          (cpuAddr),
        .tackSeen         (tackSeen),
        .extTackN         (extTackN),
        .cycle            (cycle)
    );

    ////////////////////////////////////////
    // Requesters
    ////////////////////////////////////////

    romAckDelay #(.RomDelay(RomDelay)) romAckDelay_i (
        .CLK80            (CLK80),
        .DELAYED_TACK_RST (DELAYED_TACK_RST),
        .cycle            (cycle),
        .romReq           (romReq)
    );

    ciaAckSync ciaAckSync_i (
        .CLK80            (CLK80),
        .DELAYED_TACK_RST (DELAYED_TACK_RST),
        .cycle            (cycle),
        .clk40            (clk40),
        .ciaClk           (ciaClk),
        .ciaSelN          (ciaSelN),
        .ciaReq           (ciaReq)
    );

    busTimeout #(.BusTimeout(BusTimeout)) busTimeout_i (
        .CLK80            (CLK80),
        .DELAYED_TACK_RST (DELAYED_TACK_RST),
        .cycle            (cycle),
        .timeoutReq       (timeoutReq)
    );

    // Request bundle for the arbiter
    assign req = '{rom: romReq, cia: ciaReq, timeout: timeoutReq};

    tackArbiter tackArbiter_i (
        .CLK80            (CLK80),
        .DELAYED_TACK_RST (DELAYED_TACK_RST),
        .req              (req),
        .tackN            (tackN),
        .tackOe           (tackOe),
        .tackSeen         (tackSeen),
        .termSource       (termSource)
    );

endmodule

//--- design/tackArbiter.sv
// TACK arbiter and pulse driver

module tackArbiter (
    input  logic                 CLK80,
    input  logic                 DELAYED_TACK_RST,
    input  tackPkg::ackReq_t     req,
    output logic                 tackN,
    output logic                 tackOe,
    output logic                 tackSeen,
    output tackPkg::termSource_t termSource
);
    import tackPkg::*;

    typedef enum logic [1:0] {
        TackIdle,
        TackLow1,
        TackLow2,
        TackNegate
    } tackState_t;

    tackState_t  tackState;
    ackReq_t     pending;
    ackReq_t     pendAll;
    ackReq_t     grant;
    termSource_t grantSrc;

    // New pulses join the held ones straight away
    assign pendAll = pending | req;

    ////////////////////////////////////////
    // Fixed priority grant
    ////////////////////////////////////////

    always_comb begin
        grant    = '0;
        grantSrc = SrcNone;
        // Only grant between pulses
        if (tackState == TackIdle) begin
            if (pendAll.rom) begin
                grant.rom = 1'b1;
                grantSrc  = SrcRom;
            end else if (pendAll.cia) begin
                grant.cia = 1'b1;
                grantSrc  = SrcCia;
            end else if (pendAll.timeout) begin
                grant.timeout = 1'b1;
                grantSrc      = SrcTimeout;
            end
        end
    end

    ////////////////////////////////////////
    // Pending flags and pulse FSM
    ////////////////////////////////////////

    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            pending    <= '0;
            tackState  <= TackIdle;
            termSource <= SrcNone;
        end else begin
            // Granted flag drops, the rest wait their turn
            pending <= pendAll & ~grant;
            case (tackState)
                TackIdle: begin
                    if (grant != '0) begin
                        tackState  <= TackLow1;
                        termSource <= grantSrc;
                    end
                end
                TackLow1:   tackState <= TackLow2;
                TackLow2:   tackState <= TackNegate;
                TackNegate: tackState <= TackIdle;
                default:    tackState <= TackIdle;
            endcase
        end
    end

    // Low for two cycles, then actively negated for one
    assign tackOe   = (tackState != TackIdle);
    assign tackN    = !((tackState == TackLow1) || (tackState == TackLow2));
    assign tackSeen = (tackState == TackLow1);

endmodule

//--- design/busTimeout.sv
// Unanswered cycle timeout

module busTimeout #(
    parameter logic [7:0] BusTimeout = 8'(tackPkg::DefBusTimeout)
) (
    input  logic               CLK80,
    input  logic               DELAYED_TACK_RST,
    input  tackPkg::cpuCycle_t cycle,
    output logic               timeoutReq
);
    import tackPkg::*;

    logic [7:0] toCount;
    logic [7:0] toCountNext;
    logic       toWatch;
    logic       toExpired;

    // Agnus space is always ended by Agnus, never time it
    assign toWatch     = cycle.active && (cycle.region != RegionAgnus);
    assign toCountNext = toCount + 8'd1;
    // Counter parks at the limit so only one pulse comes out
    assign toExpired   = (toCount == BusTimeout);

    ////////////////////////////////////////
    // Timeout counter
    ////////////////////////////////////////

    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            toCount    <= 8'd0;
            timeoutReq <= 1'b0;
        end else begin
            timeoutReq <= 1'b0;
            if (!toWatch) begin
                // Cycle ended by any agent, or Agnus space
                toCount <= 8'd0;
            end else if (!toExpired) begin
                toCount <= toCountNext;
                if (toCountNext == BusTimeout) begin
                    // Nobody answered, end it ourselves
                    timeoutReq <= 1'b1;
                end
            end
        end
    end

endmodule

//--- design/ciaAckSync.sv
// CIA clock synchroniser

module ciaAckSync (
    input  logic               CLK80,
    input  logic               DELAYED_TACK_RST,
    input  tackPkg::cpuCycle_t cycle,
    input  logic               clk40,
    input  logic               ciaClk,
    input  logic               ciaSelN,
    output logic               ciaReq
);
    import tackPkg::*;

    typedef enum logic [1:0] {
        CiaIdle,
        CiaWaitHigh,
        CiaWaitLow,
        CiaDone
    } ciaState_t;

    ciaState_t  ciaState;
    // Two stage synchronisers, bit 1 is the older sample
    logic [1:0] ciaClkSync;
    logic [1:0] ciaSelSync;
    logic       ciaCycle;

    assign ciaCycle = cycle.active && (cycle.region == RegionCia);

    ////////////////////////////////////////
    // Synchronisers
    ////////////////////////////////////////

    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            ciaClkSync <= 2'b00;
            ciaSelSync <= 2'b00;
        end else begin
            ciaClkSync <= {ciaClkSync[0], ciaClk};
            // Select kept active high inside
            ciaSelSync <= {ciaSelSync[0], !ciaSelN};
        end
    end

    ////////////////////////////////////////
    // Termination FSM
    ////////////////////////////////////////

    // TACK must land at or just after the E clock falling edge
    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            ciaState <= CiaIdle;
            ciaReq   <= 1'b0;
        end else begin
            ciaReq <= 1'b0;
            case (ciaState)
                CiaIdle: begin
                    // Select stable in both stages
                    if ((ciaSelSync == 2'b11) && ciaCycle) begin
                        ciaState <= CiaWaitHigh;
                    end
                end
                CiaWaitHigh: begin
                    if (ciaClkSync == 2'b11) begin
                        ciaState <= CiaWaitLow;
                    end
                end
                CiaWaitLow: begin
                    // Falling edge seen, align to the low clk40 phase
                    if ((ciaClkSync == 2'b00) && !clk40) begin
                        ciaReq   <= 1'b1;
                        ciaState <= CiaDone;
                    end
                end
                CiaDone: begin
                    // Hold off until the CIA is deselected
                    if (ciaSelSync == 2'b00) begin
                        ciaState <= CiaIdle;
                    end
                end
                default: ciaState <= CiaIdle;
            endcase
        end
    end

endmodule

//--- design/romAckDelay.sv
// ROM setup delay

module romAckDelay #(
    parameter logic [2:0] RomDelay = 3'(tackPkg::DefRomDelay)
) (
    input  logic               CLK80,
    input  logic               DELAYED_TACK_RST,
    input  tackPkg::cpuCycle_t cycle,
    output logic               romReq
);
    import tackPkg::*;

    logic [2:0] romCount;
    logic       romCycle;
    logic       romCyclePrev;
    logic       romStart;

    // Active ROM cycle from the decoder
    assign romCycle = cycle.active && (cycle.region == RegionRom);
    // Rising edge only, one pulse per cycle
    assign romStart = romCycle && !romCyclePrev;

    ////////////////////////////////////////
    // Delay counter
    ////////////////////////////////////////

    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            romCount     <= 3'd0;
            romCyclePrev <= 1'b0;
            romReq       <= 1'b0;
        end else begin
            romCyclePrev <= romCycle;
            romReq       <= 1'b0;
            if (romCount != 3'd0) begin
                if (romCount == RomDelay) begin
                    // Setup time met, ask for TACK
                    romReq   <= 1'b1;
                    romCount <= 3'd0;
                end else begin
                    romCount <= romCount + 3'd1;
                end
            end else if (romStart) begin
                // Idle counter, first look at this ROM cycle
                romCount <= 3'd1;
            end
        end
    end

endmodule

//--- design/cycleDecode.sv
// CPU cycle decoder

module cycleDecode (
    input  logic               CLK80,
    input  logic               DELAYED_TACK_RST,
    input  logic               tsN,
    input  logic               clk40,
    input  logic [31:0]        cpuAddr,
    input  logic               tackSeen,
    input  logic               extTackN,
    output tackPkg::cpuCycle_t cycle
);
    import tackPkg::*;

    ////////////////////////////////////////
    // Address match
    ////////////////////////////////////////

    region_t addrRegion;
    logic    tsStart;
    logic    cycleEnd;

    always_comb begin
        // ROM wins over everything else in the map
        if ((cpuAddr & RomMask) == RomBase) begin
            addrRegion = RegionRom;
        end else if ((cpuAddr & CiaMask) == CiaBase) begin
            addrRegion = RegionCia;
        end else if (((cpuAddr & AgnusMask) == AgnusBase) || (cpuAddr < ChipRamTop)) begin
            // Registers and chip RAM, Agnus ends these itself
            addrRegion = RegionAgnus;
        end else begin
            addrRegion = RegionOther;
        end
    end

    // TS is only valid in the high phase of clk40
    assign tsStart  = !tsN && clk40;
    // Our own pulse or any other agent on the shared line
    assign cycleEnd = tackSeen || !extTackN;

    ////////////////////////////////////////
    // Held cycle
    ////////////////////////////////////////

    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            cycle.active <= 1'b0;
            cycle.region <= RegionNone;
        end else if (cycle.active) begin
            // TS cannot repeat until this cycle ends
            if (cycleEnd) begin
                cycle.active <= 1'b0;
                cycle.region <= RegionNone;
            end
        end else if (tsStart) begin
            cycle.active <= 1'b1;
            cycle.region <= addrRegion;
        end
    end

endmodule

//--- design/tackPkg.sv
// Transfer ack shared definitions

package tackPkg;

    ////////////////////////////////////////
    // Cycle classes and sources
    ////////////////////////////////////////

    // Class of the cycle held by the decoder
    typedef enum logic [2:0] {
        RegionNone,
        RegionRom,
        RegionCia,
        RegionAgnus,
        RegionOther
    } region_t;

    // Who terminated the last cycle
    typedef enum logic [1:0] {
        SrcNone,
        SrcRom,
        SrcCia,
        SrcTimeout
    } termSource_t;

    // Single-cycle termination requests, one per local source
    typedef struct packed {
        logic rom;
        logic cia;
        logic timeout;
    } ackReq_t;

    // Held cycle, active from sampled TS until TACK
    typedef struct packed {
        region_t region;
        logic    active;
    } cpuCycle_t;

    ////////////////////////////////////////
    // Address map
    ////////////////////////////////////////

    // Kickstart ROM, 512 KiB
    localparam logic [31:0] RomBase    = 32'h00F8_0000;
    localparam logic [31:0] RomMask    = 32'hFFF8_0000;
    // CIA A and B share one 64 KiB window
    localparam logic [31:0] CiaBase    = 32'h00BF_0000;
    localparam logic [31:0] CiaMask    = 32'hFFFF_0000;
    // Custom chip registers
    localparam logic [31:0] AgnusBase  = 32'h00DF_0000;
    localparam logic [31:0] AgnusMask  = 32'hFFFF_0000;
    // Chip RAM below this is also ended by Agnus
    localparam logic [31:0] ChipRamTop = 32'h0020_0000;

    // ROM setup delay, about 62 ns at 80 MHz
    localparam integer DefRomDelay   = 5;
    // Just over the longest CIA cycle
    localparam integer DefBusTimeout = 249;

endpackage
